/* Bender.yml */
package:
  name: ram_bridge

sources:
  - hw/ram_bridge_pkg.sv
  - hw/axil_host_port.sv
  - hw/ram_word_sequencer.sv
  - hw/word_ram.sv
  - hw/ram_bridge_top.sv
  - target: simulation
    files:
      - verif/ram_bridge_tb.sv

/* hw/axil_host_port.sv */
`timescale 1ns/1ps

module axil_host_port #(
	parameter int mem_depth_log2 = 10
) (
	input  logic                       clk_sys,
	input  logic                       reset_l,
	// write address.
	input  logic                       awvalid,
	output logic                       awready,
	input  ram_bridge_pkg::axi_addr_t  awaddr,
	// write data.
	input  logic                       wvalid,
	output logic                       wready,
	input  ram_bridge_pkg::data_t      wdata,
	// write response.
	output logic                       bvalid,
	input  logic                       bready,
	output ram_bridge_pkg::axi_resp_t  bresp,
	// read address.
	input  logic                       arvalid,
	output logic                       arready,
	input  ram_bridge_pkg::axi_addr_t  araddr,
	// read data.
	output logic                       rvalid,
	input  logic                       rready,
	output ram_bridge_pkg::data_t      rdata,
	output ram_bridge_pkg::axi_resp_t  rresp,
	// request to the word sequencer.
	output logic                       req_valid,
	input  logic                       req_ready,
	output logic                       req_write,
	output ram_bridge_pkg::word_addr_t req_addr,
	output ram_bridge_pkg::data_t      req_wdata,
	input  logic                       done,
	input  ram_bridge_pkg::data_t      done_rdata
);
	import ram_bridge_pkg::*;

	// index above the ram depth means out of range.
	function automatic logic out_of_range(input axi_addr_t addr);
		axi_addr_t index;
		index = addr >> 2;
		return (index >> mem_depth_log2) != '0;
	endfunction

	// drop the byte lane bits.
	function automatic word_addr_t to_word(input axi_addr_t addr);
		return addr[word_addr_width+1:2];
	endfunction

	// **************************************************
	// holding registers and grant.
	// **************************************************

	logic      ready_en;
	logic      aw_held;
	logic      w_held;
	logic      ar_held;
	axi_addr_t aw_addr_q;
	data_t     w_data_q;
	axi_addr_t ar_addr_q;
	// write wins a tie while set.
	logic      prio_wr;
	// request handed over, waiting for done.
	logic      inflight;

	logic wr_pend;
	logic rd_pend;
	logic wr_oor;
	logic rd_oor;
	logic can_grant;
	logic grant_wr;
	logic grant_rd;
	logic issue_wr;
	logic issue_rd;
	logic seq_done;

	// readies held low until the first edge out of reset.
	assign awready = ready_en & ~aw_held;
	assign wready  = ready_en & ~w_held;
	assign arready = ready_en & ~ar_held & ~rvalid;

	assign wr_pend = aw_held & w_held;
	assign rd_pend = ar_held;
	assign wr_oor  = out_of_range(aw_addr_q);
	assign rd_oor  = out_of_range(ar_addr_q);

	// one access at a time, nothing new while a response waits.
	assign can_grant = ready_en & ~req_valid & ~inflight & ~bvalid & ~rvalid;
	assign grant_wr  = can_grant & wr_pend & (~rd_pend | prio_wr);
	assign grant_rd  = can_grant & rd_pend & (~wr_pend | ~prio_wr);
	// in range grants go to the sequencer.
	assign issue_wr  = grant_wr & ~wr_oor;
	assign issue_rd  = grant_rd & ~rd_oor;
	assign seq_done  = inflight & done;

	always_ff @(posedge clk_sys or negedge reset_l) begin
		if (!reset_l) begin
			ready_en  <= 1'b0;
			aw_held   <= 1'b0;
			w_held    <= 1'b0;
			ar_held   <= 1'b0;
			prio_wr   <= 1'b1;
			req_valid <= 1'b0;
			req_write <= 1'b0;
			inflight  <= 1'b0;
			bvalid    <= 1'b0;
			rvalid    <= 1'b0;
		end else begin
			ready_en <= 1'b1;
			// channels captured on their own.
			if (awvalid && awready) begin
				aw_held <= 1'b1;
			end else if (grant_wr) begin
				aw_held <= 1'b0;
			end
			if (wvalid && wready) begin
				w_held <= 1'b1;
			end else if (grant_wr) begin
				w_held <= 1'b0;
			end
			if (arvalid && arready) begin
				ar_held <= 1'b1;
			end else if (grant_rd) begin
				ar_held <= 1'b0;
			end
			// alternate after every grant.
			if (grant_wr || grant_rd) begin
				prio_wr <= ~prio_wr;
			end
			if (req_valid && req_ready) begin
				req_valid <= 1'b0;
			end else if (issue_wr || issue_rd) begin
				req_valid <= 1'b1;
				req_write <= issue_wr;
			end
			if (issue_wr || issue_rd) begin
				inflight <= 1'b1;
			end else if (seq_done) begin
				inflight <= 1'b0;
			end
			// responses hold until taken.
			if (bvalid && bready) begin
				bvalid <= 1'b0;
			end else if ((grant_wr && wr_oor) || (seq_done && req_write)) begin
				bvalid <= 1'b1;
			end
			if (rvalid && rready) begin
				rvalid <= 1'b0;
			end else if ((grant_rd && rd_oor) || (seq_done && !req_write)) begin
				rvalid <= 1'b1;
			end
		end
	end

	// **************************************************
	// payload.
	// **************************************************

	always_ff @(posedge clk_sys) begin
		if (awvalid && awready) begin
			aw_addr_q <= awaddr;
		end
		if (wvalid && wready) begin
			w_data_q <= wdata;
		end
		if (arvalid && arready) begin
			ar_addr_q <= araddr;
		end
		if (grant_wr) begin
			req_addr  <= to_word(aw_addr_q);
			req_wdata <= w_data_q;
		end else if (grant_rd) begin
			req_addr <= to_word(ar_addr_q);
		end
		if (grant_wr && wr_oor) begin
			bresp <= resp_slverr;
		end else if (seq_done && req_write) begin
			bresp <= resp_okay;
		end
		// out of range reads give zero data.
		if (grant_rd && rd_oor) begin
			rresp <= resp_slverr;
			rdata <= '0;
		end else if (seq_done && !req_write) begin
			rresp <= resp_okay;
			rdata <= done_rdata;
		end
	end

endmodule

/* hw/ram_bridge_pkg.sv */
package ram_bridge_pkg;

	// **************************************************
	// bus and word widths.
	// **************************************************

	// host side byte address.
	localparam int axi_addr_width = 32;
	// one data word, host and ram side.
	localparam int data_width = 32;
	// word index on the ram port.
	localparam int word_addr_width = 26;

	typedef logic [axi_addr_width-1:0] axi_addr_t;
	typedef logic [data_width-1:0] data_t;
	typedef logic [word_addr_width-1:0] word_addr_t;

	// **************************************************
	// axi response codes.
	// **************************************************

	typedef logic [1:0] axi_resp_t;

	localparam axi_resp_t resp_okay = 2'b00;
	// slave error, used for out of range words.
	localparam axi_resp_t resp_slverr = 2'b10;

	// **************************************************
	// word sequencer states.
	// **************************************************

	// idle takes a request.
	// request waits for the ram and strobes.
	// wait_read collects word_q once busy drops.
	typedef enum logic [1:0] {
		seq_idle,
		seq_request,
		seq_wait_read
	} seq_state_t;

endpackage

/* hw/ram_bridge_top.sv */
`timescale 1ns/1ps

module ram_bridge_top #(
	parameter int mem_depth_log2 = 10,
	parameter int access_cycles  = 3
) (
	input  logic                      clk_sys,
	input  logic                      reset_l,
	input  logic                      big_endian,
	// axi4-lite slave.
	input  logic                      awvalid,
	output logic                      awready,
	input  ram_bridge_pkg::axi_addr_t awaddr,
	input  logic                      wvalid,
	output logic                      wready,
	input  ram_bridge_pkg::data_t     wdata,
	output logic                      bvalid,
	input  logic                      bready,
	output ram_bridge_pkg::axi_resp_t bresp,
	input  logic                      arvalid,
	output logic                      arready,
	input  ram_bridge_pkg::axi_addr_t araddr,
	output logic                      rvalid,
	input  logic                      rready,
	output ram_bridge_pkg::data_t     rdata,
	output ram_bridge_pkg::axi_resp_t rresp
);
	import ram_bridge_pkg::*;

	// host port to sequencer.
	logic       req_valid;
	logic       req_ready;
	logic       req_write;
	word_addr_t req_addr;
	data_t      req_wdata;
	logic       done;
	data_t      done_rdata;

	// sequencer to ram.
	logic       word_rd;
	logic       word_wr;
	word_addr_t word_addr;
	data_t      word_data;
	data_t      word_q;
	logic       word_busy;

	axil_host_port #(
		.mem_depth_log2(mem_depth_log2)
	) u_host_port (
		.clk_sys(clk_sys), .reset_l(reset_l),
		.awvalid(awvalid), .awready(awready), .awaddr(awaddr),
		.wvalid(wvalid), .wready(wready), .wdata(wdata),
		.bvalid(bvalid), .bready(bready), .bresp(bresp),
		.arvalid(arvalid), .arready(arready), .araddr(araddr),
		.rvalid(rvalid), .rready(rready), .rdata(rdata), .rresp(rresp),
		.req_valid(req_valid), .req_ready(req_ready), .req_write(req_write),
		.req_addr(req_addr), .req_wdata(req_wdata),
		.done(done), .done_rdata(done_rdata)
	);

	ram_word_sequencer u_sequencer (
		.clk_sys(clk_sys), .reset_l(reset_l), .big_endian(big_endian),
		.req_valid(req_valid), .req_ready(req_ready), .req_write(req_write),
		.req_addr(req_addr), .req_wdata(req_wdata),
		.done(done), .done_rdata(done_rdata),
		.word_rd(word_rd), .word_wr(word_wr), .word_addr(word_addr),
		.word_data(word_data), .word_q(word_q), .word_busy(word_busy)
	);

	word_ram #(
		.mem_depth_log2(mem_depth_log2),
		.access_cycles(access_cycles)
	) u_ram (
		.clk_sys(clk_sys), .reset_l(reset_l),
		.word_rd(word_rd), .word_wr(word_wr), .word_addr(word_addr),
		.word_data(word_data), .word_q(word_q), .word_busy(word_busy)
	);

endmodule

/* hw/ram_word_sequencer.sv */
`timescale 1ns/1ps

module ram_word_sequencer (
	input  logic                       clk_sys,
	input  logic                       reset_l,
	// high passes bytes through, low swaps inside each halfword.
	input  logic                       big_endian,
	// request side.
	input  logic                       req_valid,
	output logic                       req_ready,
	input  logic                       req_write,
	input  ram_bridge_pkg::word_addr_t req_addr,
	input  ram_bridge_pkg::data_t      req_wdata,
	output logic                       done,
	output ram_bridge_pkg::data_t      done_rdata,
	// word port.
	output logic                       word_rd,
	output logic                       word_wr,
	output ram_bridge_pkg::word_addr_t word_addr,
	output ram_bridge_pkg::data_t      word_data,
	input  ram_bridge_pkg::data_t      word_q,
	input  logic                       word_busy
);
	import ram_bridge_pkg::*;

	// exchange the two bytes of each 16 bit half.
	function automatic data_t swap_halves(input data_t d);
		return {d[23:16], d[31:24], d[7:0], d[15:8]};
	endfunction

	seq_state_t state;
	// pending access is a read.
	logic       is_read;

	logic  take_req;
	logic  ram_free;
	data_t wdata_view;
	data_t rdata_view;

	assign req_ready = (state == seq_idle);
	assign take_req  = req_valid & req_ready;
	// free once busy is low and no strobe is still on the port.
	assign ram_free  = ~word_busy & ~word_rd & ~word_wr;

	// same swap both ways.
	assign wdata_view = big_endian ? req_wdata : swap_halves(req_wdata);
	assign rdata_view = big_endian ? word_q : swap_halves(word_q);

	// **************************************************
	// state machine.
	// **************************************************

	always_ff @(posedge clk_sys or negedge reset_l) begin
		if (!reset_l) begin
			state   <= seq_idle;
			is_read <= 1'b0;
			word_rd <= 1'b0;
			word_wr <= 1'b0;
			done    <= 1'b0;
		end else begin
			// strobes and done are single cycle.
			word_rd <= 1'b0;
			word_wr <= 1'b0;
			done    <= 1'b0;
			case (state)
				seq_request: begin
					// wait until the ram has closed its busy window.
					if (ram_free) begin
						if (is_read) begin
							word_rd <= 1'b1;
							state   <= seq_wait_read;
						end else begin
							// write completes with its strobe.
							word_wr <= 1'b1;
							done    <= 1'b1;
							state   <= seq_idle;
						end
					end
				end
				seq_wait_read: begin
					// busy is up the cycle after the strobe.
					if (ram_free) begin
						done  <= 1'b1;
						state <= seq_idle;
					end
				end
				default: begin
					if (take_req) begin
						is_read <= ~req_write;
						state   <= seq_request;
					end
				end
			endcase
		end
	end

	// **************************************************
	// address and data.
	// **************************************************

	always_ff @(posedge clk_sys) begin
		// request captured in the host view swap.
		if (take_req) begin
			word_addr <= req_addr;
			word_data <= wdata_view;
		end
		// returned word swapped on the way back.
		if (state == seq_wait_read && ram_free) begin
			done_rdata <= rdata_view;
		end
	end

endmodule

/* hw/word_ram.sv */
`timescale 1ns/1ps

module word_ram #(
	parameter int mem_depth_log2 = 10,
	// busy window length, 1 to 15.
	parameter int access_cycles  = 3
) (
	input  logic                       clk_sys,
	input  logic                       reset_l,
	input  logic                       word_rd,
	input  logic                       word_wr,
	input  ram_bridge_pkg::word_addr_t word_addr,
	input  ram_bridge_pkg::data_t      word_data,
	output ram_bridge_pkg::data_t      word_q,
	output logic                       word_busy
);
	import ram_bridge_pkg::*;

	localparam int mem_words = 2 ** mem_depth_log2;
	// wide enough for the largest window.
	localparam int cnt_width = 4;

	// **************************************************
	// storage.
	// **************************************************

	data_t mem [mem_words];

	logic [mem_depth_log2-1:0] index;
	logic                      strobe;

	// upper word bits are not decoded.
	assign index  = word_addr[mem_depth_log2-1:0];
	assign strobe = word_rd | word_wr;

	// write lands on the strobe edge.
	// read word held until the next read strobe.
	always_ff @(posedge clk_sys) begin
		if (word_wr) begin
			mem[index] <= word_data;
		end
		if (word_rd) begin
			word_q <= mem[index];
		end
	end

	// **************************************************
	// busy window.
	// **************************************************

	logic [cnt_width-1:0] busy_cnt;

	// loaded on a strobe, counts down to zero.
	always_ff @(posedge clk_sys or negedge reset_l) begin
		if (!reset_l) begin
			busy_cnt <= '0;
		end else if (strobe) begin
			busy_cnt <= cnt_width'(access_cycles);
		end else if (busy_cnt != '0) begin
			busy_cnt <= busy_cnt - 1'b1;
		end
	end

	// high for access_cycles cycles, starting after the strobe.
	assign word_busy = (busy_cnt != '0);

endmodule

/* sources.f */
hw/ram_bridge_pkg.sv
hw/axil_host_port.sv
hw/ram_word_sequencer.sv
hw/word_ram.sv
hw/ram_bridge_top.sv
verif/ram_bridge_tb.sv

/* verif/ram_bridge_tb.sv */
`timescale 1ns/1ps

module ram_bridge_tb;
	import ram_bridge_pkg::*;

	localparam int mem_depth_log2  = 10;
	localparam int access_cycles   = 4;
	localparam int mem_words       = 2 ** mem_depth_log2;
	localparam int clk_period      = 100;
	localparam int n_pool          = 64;
	// round trip, swap, range, back-pressure, channel order.
	localparam int n_accesses      = 32 + 24 + 16 + 16 + 24;
	localparam int watchdog_cycles = n_accesses * (access_cycles + 20) + 216;

	logic      clk_sys;
	logic      reset_l;
	logic      big_endian;
	logic      awvalid;
	logic      awready;
	axi_addr_t awaddr;
	logic      wvalid;
	logic      wready;
	data_t     wdata;
	logic      bvalid;
	logic      bready;
	axi_resp_t bresp;
	logic      arvalid;
	logic      arready;
	axi_addr_t araddr;
	logic      rvalid;
	logic      rready;
	data_t     rdata;
	axi_resp_t rresp;

	// stimulus pools, drawn before reset.
	integer    seed;
	axi_addr_t idx_pool [n_pool];
	data_t     data_pool [n_pool];
	logic      bp_en;

	// reference model, host view plus the mode at write time.
	data_t     ref_mem [mem_words];
	logic      ref_mode [mem_words];
	axi_resp_t b_resp_q [$];
	axi_resp_t r_resp_q [$];
	data_t     r_data_q [$];
	int        b_count;
	int        r_count;

	// held response while the master stalls.
	logic      b_stall;
	logic      r_stall;
	axi_resp_t b_hold;
	axi_resp_t r_hold;
	data_t     r_hold_data;

	ram_bridge_top #(
		.mem_depth_log2(mem_depth_log2),
		.access_cycles(access_cycles)
	) dut (
		.clk_sys(clk_sys), .reset_l(reset_l), .big_endian(big_endian),
		.awvalid(awvalid), .awready(awready), .awaddr(awaddr),
		.wvalid(wvalid), .wready(wready), .wdata(wdata),
		.bvalid(bvalid), .bready(bready), .bresp(bresp),
		.arvalid(arvalid), .arready(arready), .araddr(araddr),
		.rvalid(rvalid), .rready(rready), .rdata(rdata), .rresp(rresp)
	);

	always #(clk_period / 2) clk_sys = ~clk_sys;

	// **************************************************
	// reference and compare.
	// **************************************************

	// mode change between write and read swaps bytes per halfword.
	function automatic data_t expect_read(input data_t stored, input logic wr_mode,
		input logic rd_mode);
		data_t r;
		int    h;
		r = stored;
		if (wr_mode != rd_mode) begin
			for (h = 0; h < 2; h++) begin
				r[16*h +: 8]   = stored[16*h+8 +: 8];
				r[16*h+8 +: 8] = stored[16*h +: 8];
			end
		end
		return r;
	endfunction

	function automatic logic in_range(input axi_addr_t a);
		return (a >> 2) < mem_words;
	endfunction

	function automatic axi_addr_t addr_of(input axi_addr_t idx);
		return idx << 2;
	endfunction

	task automatic abort_run();
		$display("Test failures found");
		$fatal(1, "simulation stopped");
	endtask

	task automatic check_data(input data_t actual, input data_t expected, input string what);
		if (actual !== expected) begin
			$display("[FAIL] %0d ns: %s, got %h, expected %h", $time, what, actual, expected);
			abort_run();
		end
	endtask

	task automatic check_resp(input axi_resp_t actual, input axi_resp_t expected,
		input string what);
		if (actual !== expected) begin
			$display("[FAIL] %0d ns: %s, got %0d, expected %0d", $time, what, actual, expected);
			abort_run();
		end
	endtask

	// **************************************************
	// axi master.
	// **************************************************

	// all tasks start and end on a rising edge.
	task automatic send_aw(input axi_addr_t a);
		awvalid <= 1'b1;
		awaddr  <= a;
		do begin
			@(posedge clk_sys);
		end while (!awready);
		awvalid <= 1'b0;
	endtask

	task automatic send_w(input data_t d);
		wvalid <= 1'b1;
		wdata  <= d;
		do begin
			@(posedge clk_sys);
		end while (!wready);
		wvalid <= 1'b0;
	endtask

	task automatic send_ar(input axi_addr_t a);
		arvalid <= 1'b1;
		araddr  <= a;
		do begin
			@(posedge clk_sys);
		end while (!arready);
		arvalid <= 1'b0;
	endtask

	task automatic note_write(input axi_addr_t a, input data_t d);
		if (in_range(a)) begin
			ref_mem[a >> 2]  = d;
			ref_mode[a >> 2] = big_endian;
			b_resp_q.push_back(resp_okay);
		end else begin
			b_resp_q.push_back(resp_slverr);
		end
	endtask

	task automatic note_read(input axi_addr_t a);
		if (in_range(a)) begin
			r_resp_q.push_back(resp_okay);
			r_data_q.push_back(expect_read(ref_mem[a >> 2], ref_mode[a >> 2], big_endian));
		end else begin
			r_resp_q.push_back(resp_slverr);
			r_data_q.push_back('0);
		end
	endtask

	task automatic wait_for(input int b_target, input int r_target);
		while (b_count != b_target || r_count != r_target) begin
			@(posedge clk_sys);
		end
	endtask

	// order 1 sends W first, 2 sends AW first, else both together.
	task automatic do_write(input axi_addr_t a, input data_t d, input int order);
		int b_target;
		b_target = b_count + 1;
		note_write(a, d);
		case (order)
			1: begin
				send_w(d);
				send_aw(a);
			end
			2: begin
				send_aw(a);
				send_w(d);
			end
			default: begin
				fork
					send_aw(a);
					send_w(d);
				join
			end
		endcase
		wait_for(b_target, r_count);
	endtask

	task automatic do_read(input axi_addr_t a);
		int r_target;
		r_target = r_count + 1;
		note_read(a);
		send_ar(a);
		wait_for(b_count, r_target);
	endtask

	// write and read pending on the same edge, distinct words.
	task automatic do_pair(input axi_addr_t wa, input data_t wd, input axi_addr_t ra);
		int b_target;
		int r_target;
		b_target = b_count + 1;
		r_target = r_count + 1;
		note_write(wa, wd);
		note_read(ra);
		fork
			send_aw(wa);
			send_w(wd);
			send_ar(ra);
		join
		wait_for(b_target, r_target);
	endtask

	task automatic set_mode(input logic m);
		big_endian <= m;
		@(posedge clk_sys);
	endtask

	// **************************************************
	// response monitor.
	// **************************************************

	always @(posedge clk_sys) begin
		if (reset_l) begin
			if (b_stall) begin
				if (!bvalid) begin
					$display("write response withdrawn at %0d ns while bready was low", $time);
					abort_run();
				end
				check_resp(bresp, b_hold, "bresp under back-pressure");
			end
			if (r_stall) begin
				if (!rvalid) begin
					$display("read response withdrawn at %0d ns while rready was low", $time);
					abort_run();
				end
				check_resp(rresp, r_hold, "rresp under back-pressure");
				check_data(rdata, r_hold_data, "rdata under back-pressure");
			end
			b_stall     = bvalid && !bready;
			b_hold      = bresp;
			r_stall     = rvalid && !rready;
			r_hold      = rresp;
			r_hold_data = rdata;
			if (bvalid && bready) begin
				if (b_resp_q.size() == 0) begin
					$display("write response at %0d ns with no write outstanding", $time);
					abort_run();
				end
				check_resp(bresp, b_resp_q.pop_front(), "write response");
				b_count <= b_count + 1;
			end
			if (rvalid && rready) begin
				if (r_resp_q.size() == 0) begin
					$display("read response at %0d ns with no read outstanding", $time);
					abort_run();
				end
				check_resp(rresp, r_resp_q.pop_front(), "read response");
				check_data(rdata, r_data_q.pop_front(), "read data");
				r_count <= r_count + 1;
			end
		end
	end

	// random stalls on both response channels.
	always @(posedge clk_sys) begin
		if (bp_en) begin
			bready <= ($random(seed) & 1) != 0;
			rready <= ($random(seed) & 1) != 0;
		end else begin
			bready <= 1'b1;
			rready <= 1'b1;
		end
	end

	initial begin
		seq_state_t st;
		#(watchdog_cycles * clk_period);
		st = dut.u_sequencer.state;
		$display("timeout after %0d cycles, sequencer stuck in %s", watchdog_cycles, st.name());
		abort_run();
	end

	// **************************************************
	// test sequence.
	// **************************************************

	initial begin
		axi_addr_t a;
		int        i;
		int        k;
		clk_sys    = 1'b0;
		reset_l    = 1'b0;
		big_endian = 1'b1;
		awvalid    = 1'b0;
		awaddr     = '0;
		wvalid     = 1'b0;
		wdata      = '0;
		bready     = 1'b1;
		arvalid    = 1'b0;
		araddr     = '0;
		rready     = 1'b1;
		bp_en      = 1'b0;
		b_stall    = 1'b0;
		r_stall    = 1'b0;
		b_count    = 0;
		r_count    = 0;
		seed       = 79;
		for (i = 0; i < n_pool; i++) begin
			idx_pool[i]  = axi_addr_t'($random(seed)) & axi_addr_t'(mem_words - 1);
			data_pool[i] = $random(seed);
		end
		repeat (16) @(posedge clk_sys);
		reset_l <= 1'b1;
		@(posedge clk_sys);

		// big endian round trip.
		for (i = 0; i < 16; i++) begin
			do_write(addr_of(idx_pool[i]), data_pool[i], 0);
		end
		for (i = 0; i < 16; i++) begin
			do_read(addr_of(idx_pool[i]));
		end

		// mode changes between write and read.
		for (i = 0; i < 4; i++) begin
			k = 16 + 3 * i;
			set_mode(1'b1);
			do_write(addr_of(idx_pool[k]), data_pool[k], 0);
			set_mode(1'b0);
			do_read(addr_of(idx_pool[k]));
			do_write(addr_of(idx_pool[k+1]), data_pool[k+1], 0);
			set_mode(1'b1);
			do_read(addr_of(idx_pool[k+1]));
			set_mode(1'b0);
			do_write(addr_of(idx_pool[k+2]), data_pool[k+2], 0);
			do_read(addr_of(idx_pool[k+2]));
			set_mode(1'b1);
		end

		// out of range aliases an in range word.
		for (i = 0; i < 4; i++) begin
			k = 28 + i;
			do_write(addr_of(idx_pool[k]), data_pool[k], 0);
			if (i % 2 == 1) begin
				a = addr_of(idx_pool[k]) | 32'h8000_0000;
			end else begin
				a = addr_of(idx_pool[k] + mem_words);
			end
			do_write(a, ~data_pool[k], 0);
			do_read(a);
			do_read(addr_of(idx_pool[k]));
		end

		// response back-pressure.
		bp_en <= 1'b1;
		for (i = 0; i < 8; i++) begin
			k = 32 + i;
			do_write(addr_of(idx_pool[k]), data_pool[k], 0);
			do_read(addr_of(idx_pool[k]));
		end
		bp_en <= 1'b0;

		// channel order and read against write.
		for (i = 0; i < 4; i++) begin
			a = addr_of(idx_pool[40 + i]);
			do_write(a, data_pool[40 + i], 1);
			do_write(a ^ 4, data_pool[44 + i], 2);
			do_pair(a ^ 8, data_pool[48 + i], a);
			do_read(a ^ 4);
			do_read(a ^ 8);
		end

		// a few idle edges to catch a stray response.
		repeat (4) @(posedge clk_sys);
		$display("All tests passed!");
		$finish;
	end

endmodule
